//--- compile.f
+incdir+verif
hw/video_pkg.sv
hw/char_pkg.sv
hw/video_timer.sv
hw/cpu_access_fsm.sv
hw/char_vram.sv
hw/char_tile_fetch.sv
hw/char_pixel_shifter.sv
hw/char_layer_top.sv
verif/char_layer_tb.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module char_layer_tb -f compile.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only --timing --assert --top-module char_layer_tb -f compile.f

clean:
	rm -rf obj_dir sim.log

//--- verif/char_layer_tests.svh
// One CPU strobe, then wait for the single done pulse
task automatic cpu_access(input logic wr, input logic [10:0] addr, input logic [7:0] din,
		output logic [7:0] dout);
	int waited;
	dout = 8'h00;
	@(negedge clk);
	cpu_wr   = wr;
	cpu_rd   = !wr;
	cpu_addr = addr;
	cpu_din  = din;
	@(negedge clk);
	cpu_wr = 1'b0; // Strobe is one cycle only
	cpu_rd = 1'b0;
	waited = 1;
	while (!cpu_done && waited < 12) begin
		@(negedge clk);
		waited++;
	end
	if (!cpu_done) begin
		$display("cpu_done did not arrive within 12 cycles of the %s at address %03h",
			wr ? "write" : "read", addr);
		protocol_errors++;
	end else begin
		dout = cpu_dout; // Read data is valid with done
		@(negedge clk);
		if (cpu_done) begin
			$display("cpu_done stayed high for more than one cycle at address %03h", addr);
			protocol_errors++;
		end
	end
endtask

task automatic cpu_write(input logic [10:0] addr, input logic [7:0] data);
	logic [7:0] unused_q;
	cpu_access(1'b1, addr, data, unused_q);
	shadow[addr] = data;
endtask

task automatic cpu_read_check(input logic [10:0] addr);
	logic [7:0] q;
	cpu_access(1'b0, addr, 8'h00, q);
	check_byte(shadow[addr], q, $sformatf("read of %03h", addr));
endtask

// Codes and attributes for one row of 32 tiles
task automatic fill_tile_row(input logic [4:0] trow, input logic with_attr);
	char_pkg::char_attr_t a;
	logic [4:0]           col;
	for (int c = 0; c < int'(char_pkg::TILE_COLS); c++) begin
		col   = 5'(c);
		a.raw = 8'h00;
		if (with_attr) begin
			a.raw     = 8'($urandom); // Random code_hi
			a.f.vflip = col[0];
			a.f.hflip = col[1];
			a.f.pal   = col[4:1]; // All 16 palettes across the row
		end
		cpu_write({1'b0, trow, col}, 8'($urandom));
		cpu_write({1'b1, trow, col}, a.raw);
	end
endtask

task automatic wait_line_start(input logic [8:0] line);
	@(negedge clk);
	while (!(vcount == line && hcount == 9'd0))
		@(negedge clk);
endtask

// Every visible column of one line, sampled at hcount == x + 9
task automatic check_line(input logic [8:0] line, input logic fl);
	logic [8:0] x;
	logic [5:0] exp;
	wait_line_start(line);
	while (hcount != 9'(video_pkg::H_VISIBLE + video_pkg::PIXEL_DELAY)) begin
		@(negedge clk);
		if (hcount >= 9'(video_pkg::PIXEL_DELAY) &&
				hcount < 9'(video_pkg::H_VISIBLE + video_pkg::PIXEL_DELAY)) begin
			x   = hcount - 9'(video_pkg::PIXEL_DELAY);
			exp = predict_pixel(line, x, fl);
			check_pixel(exp[1:0], exp[5:2], pixel_col, pixel_pal,
				$sformatf("line %0d column %0d", line, x));
		end
	end
endtask

// Raster counters and idle done from reset through one full frame
task automatic test_counters();
	logic [8:0] exp_h;
	logic [8:0] exp_v;
	exp_h = 9'd0;
	exp_v = 9'd0;
	check_count(exp_h, hcount, "hcount after reset");
	check_count(exp_v, vcount, "vcount after reset");
	repeat (FRAME_CYCLES + int'(video_pkg::H_TOTAL)) begin
		@(negedge clk);
		if (exp_h == 9'(video_pkg::H_TOTAL - 1)) begin
			exp_h = 9'd0;
			exp_v = (exp_v == 9'(video_pkg::V_TOTAL - 1)) ? 9'd0 : exp_v + 9'd1;
		end else begin
			exp_h = exp_h + 9'd1;
		end
		check_count(exp_h, hcount, "hcount");
		check_count(exp_v, vcount, "vcount");
		check_flag(exp_h >= 9'(video_pkg::H_VISIBLE), hblank, "hblank");
		check_flag(exp_v >= 9'(video_pkg::V_VISIBLE), vblank, "vblank");
		check_flag(1'b0, cpu_done, "cpu_done with no request");
	end
endtask

task automatic test_cpu_rw();
	logic [10:0] addrs [$];
	logic [10:0] a;
	for (int i = 0; i < 32; i++) begin
		a = 11'($urandom);
		a[char_pkg::ATTR_PAGE_BIT] = 1'(i % 2); // Alternate code and attribute page
		cpu_write(a, 8'($urandom));
		addrs.push_back(a);
	end
	foreach (addrs[k])
		cpu_read_check(addrs[k]);
endtask

task automatic test_plain_line();
	logic [8:0] line;
	line = 9'd37;
	fill_tile_row(line[7:3], 1'b0);
	check_line(line, 1'b0);
endtask

task automatic test_attr_line();
	logic [8:0] line;
	line = 9'd90;
	fill_tile_row(line[7:3], 1'b1);
	check_line(line, 1'b0);
endtask

// Screen flip, the map row is taken from the mirrored position
task automatic test_flip_line();
	logic [8:0] line;
	line = 9'd150;
	fill_tile_row(~line[7:3], 1'b1);
	@(negedge clk);
	flip = 1'b1;
	check_line(line, 1'b1);
	@(negedge clk);
	flip = 1'b0;
endtask

// CPU traffic on other rows while the line is drawn
task automatic cpu_traffic(input logic [4:0] busy_row);
	logic [10:0] a;
	repeat (12) begin
		a = 11'($urandom);
		if (a[9:5] == busy_row)
			a[9:5] = busy_row + 5'd7; // Stay off the row on screen
		cpu_write(a, 8'($urandom));
		cpu_read_check(a);
	end
endtask

task automatic test_busy_line();
	logic [8:0] line;
	line = 9'd201;
	fill_tile_row(line[7:3], 1'b1);
	fork
		check_line(line, 1'b0);
		begin
			wait_line_start(line);
			cpu_traffic(line[7:3]);
		end
	join
endtask

//--- verif/char_layer_tb.sv
module char_layer_tb;

	// One counter frame, four rendered lines, RAM fills on top
	localparam int FRAME_CYCLES    = int'(video_pkg::H_TOTAL * video_pkg::V_TOTAL);
	localparam int WATCHDOG_CYCLES = 6 * FRAME_CYCLES + 20000;

	logic        clk;
	logic        reset;
	logic        flip;
	logic        cpu_wr;
	logic        cpu_rd;
	logic [10:0] cpu_addr;
	logic [7:0]  cpu_din;
	logic [15:0] chrom_data;
	logic [7:0]  cpu_dout;
	logic        cpu_done;
	logic [12:0] char_addr;
	logic [1:0]  pixel_col;
	logic [3:0]  pixel_pal;
	logic [8:0]  hcount;
	logic [8:0]  vcount;
	logic        hblank;
	logic        vblank;

	logic [7:0] shadow [0:2047]; // What the RAM should hold
	int         value_errors;
	int         protocol_errors;

	always #10 clk = ~clk;

	// Character ROM stand-in, fixed scramble of the address
	function automatic logic [15:0] rom_word(input logic [12:0] a);
		logic [15:0] x;
		x = {3'b000, a} * 16'd40503;
		return x ^ {a[7:0], a[12:5]} ^ 16'h3c5a;
	endfunction

	assign chrom_data = rom_word(char_addr); // Combinational, like the real part

	char_layer_top i_dut (
		.clk        (clk),
		.reset      (reset),
		.flip       (flip),
		.cpu_wr     (cpu_wr),
		.cpu_rd     (cpu_rd),
		.cpu_addr   (cpu_addr),
		.cpu_din    (cpu_din),
		.chrom_data (chrom_data),
		.cpu_dout   (cpu_dout),
		.cpu_done   (cpu_done),
		.char_addr  (char_addr),
		.pixel_col  (pixel_col),
		.pixel_pal  (pixel_pal),
		.hcount     (hcount),
		.vcount     (vcount),
		.hblank     (hblank),
		.vblank     (vblank)
	);

	task automatic check_byte(input logic [7:0] exp, input logic [7:0] got, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %02h got %02h", $time, what, exp, got);
			value_errors++;
		end
	endtask

	task automatic check_count(input logic [8:0] exp, input logic [8:0] got, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %0d got %0d", $time, what, exp, got);
			value_errors++;
		end
	endtask

	task automatic check_flag(input logic exp, input logic got, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %b got %b", $time, what, exp, got);
			value_errors++;
		end
	endtask

	task automatic check_pixel(input logic [1:0] exp_col, input logic [3:0] exp_pal,
			input logic [1:0] got_col, input logic [3:0] got_pal, input string what);
		if (got_col !== exp_col || got_pal !== exp_pal) begin
			$display("FAILED at %0t: %s expected col %0d pal %0d got col %0d pal %0d",
				$time, what, exp_col, exp_pal, got_col, got_pal);
			value_errors++;
		end
	endtask

	// Reference for one screen pixel, {pal, col}, from the shadow map
	function automatic logic [5:0] predict_pixel(input logic [8:0] line, input logic [8:0] col,
			input logic fl);
		logic [9:0]           map;
		logic [7:0]           code;
		char_pkg::char_attr_t a;
		logic [2:0]           row;
		logic [15:0]          w;
		logic [2:0]           p;
		logic [7:0]           b;
		logic [1:0]           q;
		map   = {line[7:3], col[7:3]} ^ {10{fl}}; // Flip reads the map backwards
		code  = shadow[{1'b0, map}];
		a.raw = shadow[{1'b1, map}];
		row   = line[2:0] ^ {3{a.f.vflip ^ fl}};
		w     = rom_word({a.f.code_hi, code, row});
		p     = (a.f.hflip ^ fl) ? 3'd7 - col[2:0] : col[2:0]; // Mirror reverses order
		b     = p[2] ? w[15:8] : w[7:0];
		q     = p[1:0];
		return {a.f.pal, b[3 - q], b[7 - q]};
	endfunction

	`include "char_layer_tests.svh"

	initial begin
		clk             = 1'b0;
		reset           = 1'b1;
		flip            = 1'b0;
		cpu_wr          = 1'b0;
		cpu_rd          = 1'b0;
		cpu_addr        = 11'd0;
		cpu_din         = 8'd0;
		value_errors    = 0;
		protocol_errors = 0;
		void'($urandom(30563));
		repeat (4) @(negedge clk);
		reset = 1'b0;
		test_counters();
		test_cpu_rw();
		test_plain_line();
		test_attr_line();
		test_flip_line();
		test_busy_line();
		$display("Errors: %0d value mismatches, %0d protocol failures",
			value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not end within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- hw/char_layer_top.sv
module char_layer_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        flip,
	input  logic        cpu_wr,
	input  logic        cpu_rd,
	input  logic [10:0] cpu_addr,
	input  logic [7:0]  cpu_din,
	input  logic [15:0] chrom_data,
	output logic [7:0]  cpu_dout,
	output logic        cpu_done,
	output logic [12:0] char_addr,
	output logic [1:0]  pixel_col,
	output logic [3:0]  pixel_pal,
	output logic [8:0]  hcount,
	output logic [8:0]  vcount,
	output logic        hblank,
	output logic        vblank
);

	logic        cpu_slot;
	logic        cpu_we;
	logic [10:0] cpu_ram_addr;
	logic [7:0]  cpu_ram_din;
	logic [10:0] render_addr;
	logic [7:0]  ram_q;        // Shared by CPU and renderer
	logic        mirror;
	logic [3:0]  pal;

	video_timer i_timer (
		.clk    (clk),
		.reset  (reset),
		.hcount (hcount),
		.vcount (vcount),
		.hblank (hblank),
		.vblank (vblank)
	);

	cpu_access_fsm i_cpu (
		.clk          (clk),
		.reset        (reset),
		.hcount       (hcount),
		.cpu_wr       (cpu_wr),
		.cpu_rd       (cpu_rd),
		.cpu_addr     (cpu_addr),
		.cpu_din      (cpu_din),
		.ram_q        (ram_q),
		.cpu_slot     (cpu_slot),
		.cpu_we       (cpu_we),
		.cpu_ram_addr (cpu_ram_addr),
		.cpu_ram_din  (cpu_ram_din),
		.cpu_dout     (cpu_dout),
		.cpu_done     (cpu_done)
	);

	char_vram i_vram (
		.clk          (clk),
		.cpu_slot     (cpu_slot),
		.cpu_we       (cpu_we),
		.cpu_ram_addr (cpu_ram_addr),
		.cpu_ram_din  (cpu_ram_din),
		.render_addr  (render_addr),
		.ram_q        (ram_q)
	);

	char_tile_fetch i_fetch (
		.clk         (clk),
		.reset       (reset),
		.hcount      (hcount),
		.vcount      (vcount),
		.flip        (flip),
		.ram_q       (ram_q),
		.render_addr (render_addr),
		.char_addr   (char_addr),
		.mirror      (mirror),
		.pal         (pal)
	);

	char_pixel_shifter i_shifter (
		.clk        (clk),
		.reset      (reset),
		.hcount     (hcount),
		.chrom_data (chrom_data), // Off-chip ROM, answers combinationally
		.mirror     (mirror),
		.pal        (pal),
		.pixel_col  (pixel_col),
		.pixel_pal  (pixel_pal)
	);

endmodule

//--- hw/char_pixel_shifter.sv
module char_pixel_shifter (
	input  logic        clk,
	input  logic        reset,
	input  logic [8:0]  hcount,
	input  logic [15:0] chrom_data,
	input  logic        mirror,
	input  logic [3:0]  pal,
	output logic [1:0]  pixel_col,
	output logic [3:0]  pixel_pal
);

	logic [2:0]  phase;
	logic [15:0] planes;     // Low byte shifts out, high byte waits
	logic        mirror_q;   // Direction of the tile in flight
	logic [15:0] cur;        // Word feeding this cycle's pixel
	logic        cur_mirror;
	logic [7:0]  shifted;    // Low byte after one step

	assign phase = hcount[2:0];

	always_comb begin
		cur        = planes;
		cur_mirror = mirror_q;
		case (phase)
			video_pkg::SLOT_LOAD_PHASE: begin
				cur_mirror = mirror;
				// Mirrored tiles start from the high byte
				cur = mirror ? {chrom_data[7:0], chrom_data[15:8]} : chrom_data;
			end
			3'd4: cur = {planes[15:8], planes[15:8]}; // Second half of the tile
			default: ;
		endcase
		// Both nibble planes step toward the output end
		if (cur_mirror)
			shifted = {1'b0, cur[7:5], 1'b0, cur[3:1]};
		else
			shifted = {cur[6:4], 1'b0, cur[2:0], 1'b0};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			planes    <= 16'd0;
			mirror_q  <= 1'b0;
			pixel_col <= 2'd0;
			pixel_pal <= 4'd0;
		end else begin
			planes   <= {cur[15:8], shifted};
			mirror_q <= cur_mirror;
			pixel_col <= cur_mirror ? {cur[0], cur[4]} : {cur[3], cur[7]};
			if (phase == video_pkg::SLOT_LOAD_PHASE)
				pixel_pal <= pal; // Held for all eight pixels
		end
	end

endmodule

//--- hw/char_tile_fetch.sv
module char_tile_fetch (
	input  logic        clk,
	input  logic        reset,
	input  logic [8:0]  hcount,
	input  logic [8:0]  vcount,
	input  logic        flip,
	input  logic [7:0]  ram_q,
	output logic [10:0] render_addr,
	output logic [12:0] char_addr,
	output logic        mirror,
	output logic [3:0]  pal
);

	logic [2:0] phase;
	logic [$clog2(char_pkg::TILE_COLS)-1:0] tile_col;
	logic [4:0] tile_row;
	logic [9:0] map_addr;  // Byte offset inside one page
	logic [7:0] code_q;    // Low code byte from phase 2
	logic [2:0] row;       // ROM row after flips
	char_pkg::char_attr_t attr;

	assign phase    = hcount[2:0];
	assign tile_col = hcount[7:3];
	assign tile_row = vcount[7:3];

	// Screen flip walks the map backwards in both directions
	assign map_addr = {10{flip}} ^ {tile_row, tile_col};

	// Phases 0,1 point at codes, 2,3 at attributes
	always_comb begin
		render_addr = {1'b0, map_addr};
		render_addr[char_pkg::ATTR_PAGE_BIT] = phase[1];
	end

	always_comb begin
		attr.raw = ram_q; // Valid as attribute at phase 4 only
	end

	assign row = vcount[2:0] ^ {3{attr.f.vflip ^ flip}};

	// Code byte shows up one cycle after its address
	always_ff @(posedge clk) begin
		if (phase == video_pkg::SLOT_CODE_PHASE)
			code_q <= ram_q;
	end

	// ROM address, mirror and palette for the next slot's shifter load
	always_ff @(posedge clk) begin
		if (reset) begin
			char_addr <= 13'd0;
			mirror    <= 1'b0;
			pal       <= 4'd0;
		end else if (phase == video_pkg::SLOT_ATTR_PHASE) begin
			char_addr <= {attr.f.code_hi, code_q, row};
			mirror    <= attr.f.hflip ^ flip; // Flip mirrors every tile
			pal       <= attr.f.pal;
		end
	end

endmodule

//--- hw/char_vram.sv
module char_vram (
	input  logic        clk,
	input  logic        cpu_slot,
	input  logic        cpu_we,
	input  logic [10:0] cpu_ram_addr,
	input  logic [7:0]  cpu_ram_din,
	input  logic [10:0] render_addr,
	output logic [7:0]  ram_q
);

	// 1 KB codes below, 1 KB attributes above
	logic [7:0]  mem [0:2047];
	logic [10:0] addr;
	logic        we;

	// CPU only gets the port during its slot cycle
	assign addr = cpu_slot ? cpu_ram_addr : render_addr;
	assign we   = cpu_slot & cpu_we;

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= cpu_ram_din;
		ram_q <= mem[addr]; // Registered read, old data on write
	end

	a_we_in_slot: assert property (@(posedge clk)
		cpu_we |-> cpu_slot)
		else $error("char_vram: write outside the CPU slot");

endmodule

//--- hw/cpu_access_fsm.sv
module cpu_access_fsm (
	input  logic        clk,
	input  logic        reset,
	input  logic [8:0]  hcount,
	input  logic        cpu_wr,
	input  logic        cpu_rd,
	input  logic [10:0] cpu_addr,
	input  logic [7:0]  cpu_din,
	input  logic [7:0]  ram_q,
	output logic        cpu_slot,
	output logic        cpu_we,
	output logic [10:0] cpu_ram_addr,
	output logic [7:0]  cpu_ram_din,
	output logic [7:0]  cpu_dout,
	output logic        cpu_done
);

	enum logic [1:0] {IDLE, WAIT_SLOT, ACCESS, FINISH} state;

	logic [2:0]  next_phase; // Phase of the coming cycle
	logic        slot_next;  // Next cycle belongs to the CPU
	logic        strobe;
	logic        is_wr;      // Held request type
	logic [10:0] addr_q;
	logic [7:0]  din_q;
	logic [7:0]  dout_q;     // Last read data held after done

	assign next_phase = hcount[2:0] + 3'd1;
	assign slot_next  = (next_phase == video_pkg::SLOT_CPU_PHASE);
	assign strobe     = cpu_wr | cpu_rd;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:      if (strobe) state <= slot_next ? ACCESS : WAIT_SLOT;
				WAIT_SLOT: if (slot_next) state <= ACCESS;
				ACCESS:    state <= FINISH; // RAM sees the request this cycle
				FINISH:    state <= IDLE;
				default:   state <= IDLE;
			endcase
		end
	end

	// Request capture on the strobe
	always_ff @(posedge clk) begin
		if (state == IDLE && strobe) begin
			addr_q <= cpu_addr;
			din_q  <= cpu_din;
			is_wr  <= cpu_wr;
		end
		if (state == FINISH && !is_wr)
			dout_q <= ram_q; // Hold read data for the CPU
	end

	assign cpu_slot     = (state == ACCESS);
	assign cpu_we       = (state == ACCESS) && is_wr;
	assign cpu_ram_addr = addr_q;
	assign cpu_ram_din  = din_q;

	// Read data goes straight through in the done cycle
	assign cpu_done = (state == FINISH);
	assign cpu_dout = (state == FINISH && !is_wr) ? ram_q : dout_q;

	a_one_strobe: assert property (@(posedge clk) disable iff (reset)
		!(cpu_wr && cpu_rd))
		else $error("cpu_access_fsm: read and write strobes together");

	// A new request only after the previous done
	a_strobe_idle: assert property (@(posedge clk) disable iff (reset)
		strobe |-> state == IDLE)
		else $error("cpu_access_fsm: strobe while busy");

endmodule

//--- hw/video_timer.sv
module video_timer (
	input  logic       clk,
	input  logic       reset,
	output logic [8:0] hcount,
	output logic [8:0] vcount,
	output logic       hblank,
	output logic       vblank
);

	logic h_wrap; // Last pixel of the line
	logic v_wrap; // Last line of the frame

	assign h_wrap = (hcount == 9'(video_pkg::H_TOTAL - 1));
	assign v_wrap = (vcount == 9'(video_pkg::V_TOTAL - 1));

	// Pixel counter
	always_ff @(posedge clk) begin
		if (reset) begin
			hcount <= 9'd0;
		end else if (h_wrap) begin
			hcount <= 9'd0;
		end else begin
			hcount <= hcount + 9'd1;
		end
	end

	// Line counter, steps at the end of each line
	always_ff @(posedge clk) begin
		if (reset) begin
			vcount <= 9'd0;
		end else if (h_wrap) begin
			if (v_wrap)
				vcount <= 9'd0;
			else
				vcount <= vcount + 9'd1;
		end
	end

	assign hblank = (hcount >= 9'(video_pkg::H_VISIBLE)); // Right of column 255
	assign vblank = (vcount >= 9'(video_pkg::V_VISIBLE)); // Below line 223

	// Counters stay inside the raster
	a_raster_range: assert property (@(posedge clk) disable iff (reset)
		(hcount < 9'(video_pkg::H_TOTAL)) && (vcount < 9'(video_pkg::V_TOTAL)))
		else $error("video_timer: counter left the raster");

endmodule

//--- hw/char_pkg.sv
package char_pkg;

	// Address bit 10 splits the 2 KB RAM into code and attribute pages
	localparam int unsigned ATTR_PAGE_BIT = 10;

	// Tiles per map row, one byte each
	localparam int unsigned TILE_COLS = 32;

	// Attribute byte
	// The CPU writes it as a plain byte, the renderer picks the fields apart
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] code_hi; // Upper code bits, 1024 tiles
			logic       vflip;
			logic       hflip;
			logic [3:0] pal;     // Palette select
		} f;
	} char_attr_t;

endpackage

//--- hw/video_pkg.sv
package video_pkg;

	// Raster size in pixel clocks and lines
	localparam int unsigned H_TOTAL   = 384;
	localparam int unsigned V_TOTAL   = 264;
	localparam int unsigned H_VISIBLE = 256; // 32 tiles across
	localparam int unsigned V_VISIBLE = 224; // 28 tile rows

	// Slot phases, hcount[2:0] inside each 8-pixel slot
	// Phases 0-3 go to the renderer, 4-7 to the CPU
	localparam logic [2:0] SLOT_LOAD_PHASE = 3'd0; // Shifter takes the ROM row
	localparam logic [2:0] SLOT_CODE_PHASE = 3'd2; // Code byte on ram_q
	localparam logic [2:0] SLOT_ATTR_PHASE = 3'd4; // Attribute byte on ram_q
	localparam logic [2:0] SLOT_CPU_PHASE  = 3'd4; // First CPU-owned phase

	// Column x shows up when hcount == x + PIXEL_DELAY
	localparam int unsigned PIXEL_DELAY = 9;

endpackage
